// File: rtl/ka_pkg.sv
package ka_pkg;

	localparam int WORD_W = 36;
	localparam int ADDR_W = 18;
	localparam int FM_ADDR_W = 4;
	localparam int FM_WORDS = 1 << FM_ADDR_W;

	// Core request without address acknowledge is dropped after this
	localparam int NXM_CYCLES = 64;
	localparam int NXM_CNT_W = $clog2(NXM_CYCLES);

	// Bit 0 is the sign bit, as on the console lights
	typedef logic [0:WORD_W-1] word_t;

	// Addresses keep their word bit numbers 18..35
	typedef logic [WORD_W-ADDR_W:WORD_W-1] addr_t;

	// Accumulator number is the low end of an address
	typedef logic [WORD_W-FM_ADDR_W:WORD_W-1] fm_addr_t;

	// Console key sequencer
	typedef enum logic [1:0] {
		KS_IDLE,
		KS_WAIT_FM,	// Accumulator access
		KS_WAIT_CORE,	// Membus cycle
		KS_FINISH	// key_done
	} key_state_t;

	// Membus cycle controller
	typedef enum logic [1:0] {
		MC_IDLE,
		MC_ADR_WAIT,	// Request lines up
		MC_RD_WAIT,
		MC_WR_RS	// Write restart to memory
	} mc_state_t;

endpackage

// File: rtl/ka_console.sv
`timescale 1ns/1ps

module ka_console (
	input logic clk,
	input logic pi_reset,

	// Keys, single cycle strobes
	input logic key_exa,
	input logic key_ex_nxt,
	input logic key_dep,
	input logic key_dep_nxt,

	input logic fm_enable_sw,
	input ka_pkg::addr_t as,
	input ka_pkg::word_t ds,

	output ka_pkg::word_t ar,
	output ka_pkg::addr_t ma,
	output logic key_busy,
	output logic key_done,
	output logic nxm,

	// Fast memory
	output logic fm_rq,
	output logic fm_wr,
	output ka_pkg::fm_addr_t fm_adr,
	output ka_pkg::word_t fm_wdata,
	input logic fm_done,
	input ka_pkg::word_t fm_rdata,

	// Core memory controller
	output logic core_rq,
	output logic core_wr,
	output ka_pkg::addr_t core_adr,
	output ka_pkg::word_t core_wdata,
	input logic core_done,
	input logic core_nxm,
	input ka_pkg::word_t core_rdata
);
	import ka_pkg::*;

	key_state_t state;
	logic dep_f;	// Deposit or deposit next running
	logic key_any;
	logic key_next;
	logic key_dep_any;
	logic accept;
	logic to_fm;
	addr_t ma_next;

	assign key_any = key_exa | key_ex_nxt | key_dep | key_dep_nxt;

	// Examine wins over examine next, over deposit, over deposit next
	assign key_next = ~key_exa & (key_ex_nxt | ~key_dep & key_dep_nxt);
	assign key_dep_any = ~key_exa & ~key_ex_nxt & (key_dep | key_dep_nxt);

	// Keys in FINISH start the next function right away
	assign accept = key_any & (state == KS_IDLE || state == KS_FINISH);

	assign ma_next = key_next ? ma + 1'b1 : as;	// Wraps at 18 bits

	// Bits 18..31 zero selects an accumulator
	assign to_fm = fm_enable_sw &&
		ma_next[WORD_W-ADDR_W:WORD_W-FM_ADDR_W-1] == '0;

	assign key_busy = state == KS_WAIT_FM || state == KS_WAIT_CORE;
	assign key_done = state == KS_FINISH;

	// Write data is AR, loaded from the data switches
	assign fm_wr = dep_f;
	assign fm_adr = ma[WORD_W-FM_ADDR_W:WORD_W-1];
	assign fm_wdata = ar;
	assign core_wr = dep_f;
	assign core_adr = ma;
	assign core_wdata = ar;

	always_ff @(posedge clk) begin
		if (pi_reset) begin
			state <= KS_IDLE;
			ma <= '0;
			ar <= '0;
			nxm <= 1'b0;
			dep_f <= 1'b0;
			fm_rq <= 1'b0;
			core_rq <= 1'b0;
		end else begin
			fm_rq <= 1'b0;
			core_rq <= 1'b0;
			case (state)
			KS_WAIT_FM: begin
				if (fm_done) begin
					if (!dep_f)
						ar <= ar | fm_rdata;
					state <= KS_FINISH;
				end
			end
			KS_WAIT_CORE: begin
				if (core_done) begin
					if (!dep_f)
						ar <= ar | core_rdata;	// Zero data on NXM
					nxm <= core_nxm;
					state <= KS_FINISH;
				end
			end
			default: begin
				if (accept) begin
					ma <= ma_next;
					ar <= key_dep_any ? ds : '0;
					dep_f <= key_dep_any;
					nxm <= 1'b0;
					fm_rq <= to_fm;
					core_rq <= !to_fm;
					state <= to_fm ? KS_WAIT_FM : KS_WAIT_CORE;
				end else begin
					state <= KS_IDLE;
				end
			end
			endcase
		end
	end

	// Each function goes to exactly one memory
	a_one_target: assert property (@(posedge clk) disable iff (pi_reset)
		!(fm_rq && core_rq));

	// A request only starts when the previous one has been answered
	a_no_overlap: assert property (@(posedge clk) disable iff (pi_reset)
		(fm_rq || core_rq) |-> !$past(key_busy));

endmodule

// File: rtl/ka_fast_mem.sv
`timescale 1ns/1ps

module ka_fast_mem (
	input logic clk,
	input logic pi_reset,

	input logic fm_rq,	// Strobe
	input logic fm_wr,
	input ka_pkg::fm_addr_t fm_adr,
	input ka_pkg::word_t fm_wdata,

	output logic fm_done,
	output ka_pkg::word_t fm_rdata	// Valid with fm_done
);
	import ka_pkg::*;

	word_t fmem [0:FM_WORDS-1];	// AC0..AC17 octal

	// Accumulators clear on reset
	always_ff @(posedge clk) begin
		if (pi_reset) begin
			fm_done <= 1'b0;
			for (int i = 0; i < FM_WORDS; i++)
				fmem[i] <= '0;
		end else begin
			fm_done <= fm_rq;
			if (fm_rq && fm_wr)
				fmem[fm_adr] <= fm_wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (fm_rq && !fm_wr)
			fm_rdata <= fmem[fm_adr];
	end

	// Never back to back from the console
	a_fm_gap: assert property (@(posedge clk) disable iff (pi_reset)
		fm_rq |=> !fm_rq);

endmodule

// File: rtl/ka_mem_ctl.sv
`timescale 1ns/1ps

module ka_mem_ctl (
	input logic clk,
	input logic pi_reset,

	// From the console
	input logic core_rq,	// Strobe
	input logic core_wr,
	input ka_pkg::addr_t core_adr,
	input ka_pkg::word_t core_wdata,

	// Memory side answers
	input logic membus_addr_ack,	// Pulse
	input logic membus_rd_rs,	// Pulse
	input ka_pkg::word_t membus_mb_in,

	output logic core_done,
	output logic core_nxm,
	output ka_pkg::word_t core_rdata,

	// Membus
	output logic membus_rq_cyc,
	output logic membus_rd_rq,
	output logic membus_wr_rq,
	output logic membus_wr_rs,	// Pulse
	output ka_pkg::addr_t membus_ma,
	output ka_pkg::word_t membus_mb_out
);
	import ka_pkg::*;

	mc_state_t state;
	logic [NXM_CNT_W-1:0] nxm_cnt;	// Cycles since core_rq
	logic start;
	logic rd_hit;
	logic nxm_hit;

	assign start = state == MC_IDLE && core_rq;
	assign rd_hit = state == MC_RD_WAIT && membus_rd_rs;

	// Nobody answered the address, give up
	assign nxm_hit = state == MC_ADR_WAIT && !membus_addr_ack &&
		nxm_cnt == NXM_CNT_W'(NXM_CYCLES - 1);

	assign membus_wr_rs = state == MC_WR_RS;

	always_ff @(posedge clk) begin
		if (pi_reset) begin
			state <= MC_IDLE;
			membus_rq_cyc <= 1'b0;
			membus_rd_rq <= 1'b0;
			membus_wr_rq <= 1'b0;
			core_done <= 1'b0;
			core_nxm <= 1'b0;
			nxm_cnt <= '0;
		end else begin
			core_done <= 1'b0;
			case (state)
			MC_IDLE: begin
				if (core_rq) begin
					membus_rq_cyc <= 1'b1;
					membus_rd_rq <= !core_wr;
					membus_wr_rq <= core_wr;
					core_nxm <= 1'b0;
					nxm_cnt <= NXM_CNT_W'(1);
					state <= MC_ADR_WAIT;
				end
			end
			MC_ADR_WAIT: begin
				nxm_cnt <= nxm_cnt + 1'b1;
				if (membus_addr_ack || nxm_hit) begin
					membus_rq_cyc <= 1'b0;
					membus_rd_rq <= 1'b0;
					membus_wr_rq <= 1'b0;
				end
				if (membus_addr_ack)
					state <= membus_wr_rq ? MC_WR_RS : MC_RD_WAIT;
				else if (nxm_hit) begin
					core_done <= 1'b1;
					core_nxm <= 1'b1;
					state <= MC_IDLE;
				end
			end
			MC_RD_WAIT: begin
				if (membus_rd_rs) begin
					core_done <= 1'b1;
					state <= MC_IDLE;
				end
			end
			default: begin	// MC_WR_RS
				core_done <= 1'b1;
				state <= MC_IDLE;
			end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			membus_ma <= core_adr;
			membus_mb_out <= core_wdata;
		end
		if (rd_hit)
			core_rdata <= membus_mb_in;
		else if (nxm_hit || state == MC_WR_RS)
			core_rdata <= '0;
	end

	// Write restart only follows an acknowledged write request
	a_wr_rs: assert property (@(posedge clk) disable iff (pi_reset)
		membus_wr_rs |-> $past(membus_wr_rq) && $past(membus_addr_ack));

	// Memory sees steady request lines until it acknowledges
	a_rq_stable: assert property (@(posedge clk) disable iff (pi_reset)
		membus_rq_cyc && !membus_addr_ack && !nxm_hit |=>
			membus_rq_cyc && $stable({membus_rd_rq, membus_wr_rq, membus_ma}));

endmodule

// File: rtl/ka_top.sv
`timescale 1ns/1ps

module ka_top (
	input logic clk,
	input logic pi_reset,

	input logic key_exa,
	input logic key_ex_nxt,
	input logic key_dep,
	input logic key_dep_nxt,
	input logic fm_enable_sw,
	input ka_pkg::addr_t as,
	input ka_pkg::word_t ds,

	output ka_pkg::word_t ar,
	output ka_pkg::addr_t ma,
	output logic key_busy,
	output logic key_done,
	output logic nxm,

	// Membus
	input logic membus_addr_ack,
	input logic membus_rd_rs,
	input ka_pkg::word_t membus_mb_in,
	output logic membus_rq_cyc,
	output logic membus_rd_rq,
	output logic membus_wr_rq,
	output logic membus_wr_rs,
	output ka_pkg::addr_t membus_ma,
	output ka_pkg::word_t membus_mb_out
);
	import ka_pkg::*;

	logic fm_rq;
	logic fm_wr;
	fm_addr_t fm_adr;
	word_t fm_wdata;
	logic fm_done;
	word_t fm_rdata;

	logic core_rq;
	logic core_wr;
	addr_t core_adr;
	word_t core_wdata;
	logic core_done;
	logic core_nxm;
	word_t core_rdata;

	ka_console u_console (
		.clk(clk), .pi_reset(pi_reset),
		.key_exa(key_exa), .key_ex_nxt(key_ex_nxt),
		.key_dep(key_dep), .key_dep_nxt(key_dep_nxt),
		.fm_enable_sw(fm_enable_sw), .as(as), .ds(ds),
		.ar(ar), .ma(ma), .key_busy(key_busy), .key_done(key_done), .nxm(nxm),
		.fm_rq(fm_rq), .fm_wr(fm_wr), .fm_adr(fm_adr), .fm_wdata(fm_wdata),
		.fm_done(fm_done), .fm_rdata(fm_rdata),
		.core_rq(core_rq), .core_wr(core_wr), .core_adr(core_adr),
		.core_wdata(core_wdata), .core_done(core_done), .core_nxm(core_nxm),
		.core_rdata(core_rdata)
	);

	ka_fast_mem u_fast_mem (
		.clk(clk), .pi_reset(pi_reset),
		.fm_rq(fm_rq), .fm_wr(fm_wr), .fm_adr(fm_adr), .fm_wdata(fm_wdata),
		.fm_done(fm_done), .fm_rdata(fm_rdata)
	);

	ka_mem_ctl u_mem_ctl (
		.clk(clk), .pi_reset(pi_reset),
		.core_rq(core_rq), .core_wr(core_wr), .core_adr(core_adr),
		.core_wdata(core_wdata),
		.membus_addr_ack(membus_addr_ack), .membus_rd_rs(membus_rd_rs),
		.membus_mb_in(membus_mb_in),
		.core_done(core_done), .core_nxm(core_nxm), .core_rdata(core_rdata),
		.membus_rq_cyc(membus_rq_cyc), .membus_rd_rq(membus_rd_rq),
		.membus_wr_rq(membus_wr_rq), .membus_wr_rs(membus_wr_rs),
		.membus_ma(membus_ma), .membus_mb_out(membus_mb_out)
	);

endmodule

// File: dv/ka_membus_model.sv
`timescale 1ns/1ps

module ka_membus_model #(
	parameter int AW = 9,	// Words present, 2**AW
	parameter int unsigned SEED = 1
) (
	input logic clk,
	input logic membus_rq_cyc,
	input logic membus_rd_rq,
	input logic membus_wr_rs,
	input ka_pkg::addr_t membus_ma,
	input ka_pkg::word_t membus_mb_out,
	output logic membus_addr_ack,
	output logic membus_rd_rs,
	output ka_pkg::word_t membus_mb_in
);
	import ka_pkg::*;

	word_t mem [0:(1 << AW)-1];
	int unsigned seed = SEED;

	// 1 to 8 cycles
	function automatic int delay_next();
		seed = seed * 32'd1103515245 + 32'd12345;
		return 1 + int'((seed >> 16) % 8);
	endfunction

	// One bus cycle at a time, all edges on the falling clock
	initial begin
		logic [AW-1:0] adr;
		logic rd;
		membus_addr_ack = 1'b0;
		membus_rd_rs = 1'b0;
		membus_mb_in = '0;
		for (int i = 0; i < (1 << AW); i++)
			mem[i] = '0;
		forever begin
			@(negedge clk);
			if (membus_rq_cyc && (membus_ma >> AW) == '0) begin	// Above the top stays silent
				adr = AW'(membus_ma);
				rd = membus_rd_rq;
				repeat (delay_next() - 1) @(negedge clk);
				membus_addr_ack = 1'b1;
				@(negedge clk);
				membus_addr_ack = 1'b0;
				if (rd) begin
					repeat (delay_next() - 1) @(negedge clk);
					membus_mb_in = mem[adr];
					membus_rd_rs = 1'b1;
					@(negedge clk);
					membus_rd_rs = 1'b0;
				end else if (membus_wr_rs)
					mem[adr] = membus_mb_out;	// Write restart with data
			end
		end
	end

endmodule

// File: dv/ka_tb.sv
`timescale 1ns/1ps

module ka_tb;
	import ka_pkg::*;

	localparam int MEM_AW = 9;	// 512 words, 512..1023 is the hole
	localparam int unsigned SEED = 43715;
	localparam int N_RAND = 12;
	localparam int N_RUN = 8;
	localparam int N_AC = 16;
	localparam int N_OPS = 3 * N_RAND + 2 * (N_RUN + 1) + 5 * N_AC + 8;

	logic clk;
	logic pi_reset;
	logic key_exa;
	logic key_ex_nxt;
	logic key_dep;
	logic key_dep_nxt;
	logic fm_enable_sw;
	addr_t as;
	word_t ds;
	word_t ar;
	addr_t ma;
	logic key_busy;
	logic key_done;
	logic nxm;
	logic membus_addr_ack;
	logic membus_rd_rs;
	word_t membus_mb_in;
	logic membus_rq_cyc;
	logic membus_rd_rq;
	logic membus_wr_rq;
	logic membus_wr_rs;
	addr_t membus_ma;
	word_t membus_mb_out;

	word_t core_ref [0:(1 << MEM_AW)-1];
	word_t ac_ref [0:N_AC-1];
	word_t exp_ar;
	addr_t exp_ma;
	logic exp_nxm;
	logic exp_fm;
	logic exp_wr;	// Deposit running
	logic fm_only;	// No bus cycle allowed
	string test_name;
	int lat = 0;	// Cycles since the accepted key
	int done_cnt = 0;
	int unsigned seed = SEED;

	ka_top DUT (.*);
	ka_membus_model #(.AW(MEM_AW), .SEED(SEED)) u_mem (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		if (key_done)
			done_cnt <= done_cnt + 1;
		if (!key_busy && (key_exa || key_ex_nxt || key_dep || key_dep_nxt))
			lat <= 1;
		else
			lat <= lat + 1;
	end

	function automatic int unsigned lcg_next();
		seed = seed * 32'd1103515245 + 32'd12345;
		return seed >> 8;
	endfunction

	function automatic word_t rand_word();
		return word_t'({lcg_next(), lcg_next()});
	endfunction

	function automatic addr_t rand_core_addr();
		return addr_t'(N_AC + lcg_next() % ((1 << MEM_AW) - N_AC));
	endfunction

	task automatic report_mismatch(input string what, input word_t exp, input word_t act);
		$display("FAIL %s: %s expected %0o actual %0o", test_name, what, exp, act);
		$display("TEST RESULT: FAIL");
		$fatal(1, "%s mismatch", what);
	endtask

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("TEST RESULT: FAIL");
		$fatal(1, "%s", msg);
	endtask

	// Expected result comes from the reference arrays
	task automatic start_key(input logic nxt, input logic dep, input addr_t a, input word_t d);
		addr_t m;
		logic to_ac;
		logic to_core;
		m = nxt ? addr_t'(exp_ma + 1'b1) : a;
		to_ac = fm_enable_sw && (m >> 4) == '0;
		to_core = !to_ac && (m >> MEM_AW) == '0;
		exp_ma = m;
		exp_nxm = !to_ac && !to_core;
		exp_fm = to_ac;
		exp_wr = dep;
		if (dep)
			exp_ar = d;
		else
			exp_ar = to_ac ? ac_ref[4'(m)] : to_core ? core_ref[MEM_AW'(m)] : '0;
		if (dep && to_ac)
			ac_ref[4'(m)] = d;
		else if (dep && to_core)
			core_ref[MEM_AW'(m)] = d;
		@(negedge clk);
		as = a;
		ds = d;
		{key_exa, key_ex_nxt, key_dep, key_dep_nxt} = 4'b1000 >> {dep, nxt};
		@(negedge clk);
		{key_exa, key_ex_nxt, key_dep, key_dep_nxt} = 4'b0000;
	endtask

	task automatic wait_done();
		while (!key_done)
			@(negedge clk);
		@(negedge clk);	// Checks at the next edge still see this key
	endtask

	task automatic press(input logic nxt, input logic dep, input addr_t a, input word_t d);
		start_key(nxt, dep, a, d);
		wait_done();
	endtask

	a_ar: assert property (@(posedge clk) disable iff (pi_reset) key_done |-> ar == exp_ar)
		else report_mismatch("AR", exp_ar, ar);
	a_ma: assert property (@(posedge clk) disable iff (pi_reset) key_done |-> ma == exp_ma)
		else report_mismatch("MA", word_t'(exp_ma), word_t'(ma));
	a_nxm: assert property (@(posedge clk) disable iff (pi_reset) key_done |-> nxm == exp_nxm)
		else report_mismatch("NXM", word_t'(exp_nxm), word_t'(nxm));
	a_fm_lat: assert property (@(posedge clk) disable iff (pi_reset)
		key_done && exp_fm |-> lat == 3)
		else report_mismatch("latency", word_t'(3), word_t'(lat));
	a_nxm_lat: assert property (@(posedge clk) disable iff (pi_reset)
		key_done && exp_nxm |-> lat >= NXM_CYCLES)
		else report_mismatch("minimum latency", word_t'(NXM_CYCLES), word_t'(lat));
	a_no_bus: assert property (@(posedge clk) disable iff (pi_reset) fm_only |-> !membus_rq_cyc)
		else abort_run("Core bus cycle started during a fast memory access");
	a_bus_dir: assert property (@(posedge clk) disable iff (pi_reset)
		membus_rq_cyc |-> {membus_rd_rq, membus_wr_rq} == {!exp_wr, exp_wr})
		else report_mismatch("bus direction", word_t'({!exp_wr, exp_wr}),
			word_t'({membus_rd_rq, membus_wr_rq}));

	initial begin
		repeat ((N_OPS + 1) * (NXM_CYCLES + 20)) @(posedge clk);
		abort_run("Timeout: the tests did not finish in the allowed time");
	end

	initial begin
		addr_t a;
		addr_t b;
		int c0;
		pi_reset = 1'b1;
		{key_exa, key_ex_nxt, key_dep, key_dep_nxt} = 4'b0000;
		fm_enable_sw = 1'b1;
		as = '0;
		ds = '0;
		exp_ar = '0;
		exp_ma = '0;
		exp_nxm = 1'b0;
		exp_fm = 1'b0;
		exp_wr = 1'b0;
		fm_only = 1'b0;
		for (int i = 0; i < (1 << MEM_AW); i++)
			core_ref[i] = '0;
		for (int i = 0; i < N_AC; i++)
			ac_ref[i] = '0;
		test_name = "reset";
		repeat (3) @(posedge clk);
		@(negedge clk);
		pi_reset = 1'b0;
		if (ar !== '0 || ma !== '0 || key_busy !== 1'b0 || key_done !== 1'b0 ||
			nxm !== 1'b0 || membus_rq_cyc !== 1'b0 || membus_rd_rq !== 1'b0 ||
			membus_wr_rq !== 1'b0 || membus_wr_rs !== 1'b0)
			abort_run("Outputs not cleared by reset");

		test_name = "core deposit and examine";
		for (int i = 0; i < N_RAND; i++) begin
			a = rand_core_addr();
			press(1'b0, 1'b1, a, rand_word());
			press(1'b0, 1'b0, a, '0);
			press(1'b0, 1'b0, rand_core_addr(), '0);
		end

		test_name = "next runs";
		b = addr_t'(200 + lcg_next() % 256);
		press(1'b0, 1'b1, b, rand_word());
		for (int i = 0; i < N_RUN; i++)
			press(1'b1, 1'b1, '0, rand_word());
		press(1'b0, 1'b0, b, '0);
		for (int i = 0; i < N_RUN; i++)
			press(1'b1, 1'b0, '0, '0);

		test_name = "fast memory disabled";
		fm_enable_sw = 1'b0;
		for (int i = 0; i < N_AC; i++)
			press(1'b0, 1'b1, addr_t'(i), rand_word());
		for (int i = 0; i < N_AC; i++)
			press(1'b0, 1'b0, addr_t'(i), '0);

		test_name = "fast memory";
		fm_enable_sw = 1'b1;
		fm_only = 1'b1;
		for (int i = 0; i < N_AC; i++)
			press(1'b0, 1'b1, addr_t'(i), rand_word());
		for (int i = 0; i < N_AC; i++)
			press(1'b0, 1'b0, addr_t'(i), '0);
		fm_only = 1'b0;
		test_name = "core behind accumulators";
		fm_enable_sw = 1'b0;
		for (int i = 0; i < N_AC; i++)
			press(1'b0, 1'b0, addr_t'(i), '0);
		fm_enable_sw = 1'b1;

		test_name = "non-existent memory";
		a = addr_t'((1 << MEM_AW) + lcg_next() % (1 << MEM_AW));
		press(1'b0, 1'b0, a, '0);
		press(1'b0, 1'b1, a, rand_word());
		press(1'b1, 1'b0, '0, '0);
		press(1'b0, 1'b0, rand_core_addr(), '0);	// nxm back low

		test_name = "key while busy";
		a = rand_core_addr();
		b = rand_core_addr();
		c0 = done_cnt;
		start_key(1'b0, 1'b1, a, rand_word());
		if (!key_busy)
			abort_run("Console not busy when the second key was pressed");
		as = b;
		ds = rand_word();
		key_dep = 1'b1;
		@(negedge clk);
		key_dep = 1'b0;
		wait_done();
		repeat (NXM_CYCLES) @(negedge clk);
		if (done_cnt - c0 != 1)
			report_mismatch("key_done count", word_t'(1), word_t'(done_cnt - c0));
		press(1'b0, 1'b0, a, '0);
		press(1'b0, 1'b0, b, '0);

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// File: all.f
rtl/ka_pkg.sv
rtl/ka_console.sv
rtl/ka_fast_mem.sv
rtl/ka_mem_ctl.sv
rtl/ka_top.sv
dv/ka_membus_model.sv
dv/ka_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the console testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module ka_tb -f all.f -o ka_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi
./obj_dir/ka_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
fi
if grep -q "^TEST RESULT: PASS$" sim.log; then
	exit 0
fi
exit 1
